/* hw/fabric_consts.svh */
`ifndef FABRIC_CONSTS_SVH
`define FABRIC_CONSTS_SVH

// top nibble of the address
`define REGION_VECT    4'h1
`define REGION_SCRATCH 4'h2
`define REGION_IO      4'h4

// ram depths in words
`define VECT_WORDS     32
`define SCRATCH_WORDS  256

// io block word offsets
`define IO_LEDS        0
`define IO_SWITCHES    1
`define IO_TIMER       2
`define IO_STATUS      3

`endif

/* hw/fabric_pkg.sv */
`include "fabric_consts.svh"

package fabric_pkg;

  typedef struct packed {
    logic [3:0]  region;
    logic [27:0] offset;
  } addr_fields_t;

  // host drives a flat word, decoder and slaves split it
  typedef union packed {
    logic [31:0]  word;
    addr_fields_t f;
  } bus_addr_u;

  typedef struct packed {
    bus_addr_u   addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        rd;
    logic        wr;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        wait_level;
  } slave_rsp_t;

  // values match the top address nibble
  typedef enum logic [3:0] {
    region_none    = 4'h0,
    region_vect    = `REGION_VECT,
    region_scratch = `REGION_SCRATCH,
    region_io      = `REGION_IO
  } region_t;

endpackage

/* hw/addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder (
  input  logic                 clock_50,
  input  logic                 rst_n,
  input  fabric_pkg::bus_req_t host_req,
  input  logic                 done,
  output fabric_pkg::bus_req_t stage_req,
  output fabric_pkg::region_t  region,
  output logic                 fault
);

  logic pending;
  logic host_strobe;

  assign pending     = stage_req.rd | stage_req.wr;
  assign host_strobe = host_req.rd | host_req.wr;

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      stage_req <= '0;
      region    <= fabric_pkg::region_none;
      fault     <= 1'b0;
    end else begin
      fault <= 1'b0;
      if (pending) begin
        // host still holds the request here, so drop ours
        if (done) begin
          stage_req.rd <= 1'b0;
          stage_req.wr <= 1'b0;
        end
      end else if (host_strobe) begin
        stage_req <= host_req;
        case (host_req.addr.f.region)
          fabric_pkg::region_vect: begin
            region <= fabric_pkg::region_vect;
          end
          fabric_pkg::region_scratch: begin
            region <= fabric_pkg::region_scratch;
          end
          fabric_pkg::region_io: begin
            region <= fabric_pkg::region_io;
          end
          default: begin
            // unmapped, single cycle fault
            region <= fabric_pkg::region_none;
            fault  <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

/* hw/slave_router.sv */
`timescale 1ns/1ps

module slave_router (
  input  fabric_pkg::bus_req_t   stage_req,
  input  fabric_pkg::region_t    region,
  input  logic                   fault,
  input  fabric_pkg::slave_rsp_t vect_rsp,
  input  fabric_pkg::slave_rsp_t scratch_rsp,
  input  fabric_pkg::slave_rsp_t io_rsp,
  output logic                   vect_rd,
  output logic                   vect_wr,
  output logic                   scratch_rd,
  output logic                   scratch_wr,
  output logic                   io_rd,
  output logic                   io_wr,
  output logic [31:0]            readdata,
  output logic                   wait_level,
  output logic                   done
);

  logic                   strobe;
  fabric_pkg::slave_rsp_t sel_rsp;

  assign strobe = stage_req.rd | stage_req.wr;

  always_comb begin
    vect_rd    = 1'b0;
    vect_wr    = 1'b0;
    scratch_rd = 1'b0;
    scratch_wr = 1'b0;
    io_rd      = 1'b0;
    io_wr      = 1'b0;
    case (region)
      fabric_pkg::region_vect: begin
        vect_rd = stage_req.rd;
        vect_wr = stage_req.wr;
        sel_rsp = vect_rsp;
      end
      fabric_pkg::region_scratch: begin
        scratch_rd = stage_req.rd;
        scratch_wr = stage_req.wr;
        sel_rsp    = scratch_rsp;
      end
      fabric_pkg::region_io: begin
        io_rd   = stage_req.rd;
        io_wr   = stage_req.wr;
        sel_rsp = io_rsp;
      end
      default: begin
        sel_rsp.rdata      = 32'h0;
        sel_rsp.wait_level = 1'b1;
      end
    endcase
    // unmapped access ends at once with zero data
    if (fault) begin
      sel_rsp.rdata      = 32'h0;
      sel_rsp.wait_level = 1'b0;
    end
  end

  assign readdata = sel_rsp.rdata;

  // idle bus reads as waiting
  assign wait_level = strobe ? sel_rsp.wait_level : 1'b1;
  assign done       = strobe & ~wait_level;

endmodule

/* hw/onchip_ram.sv */
`timescale 1ns/1ps

module onchip_ram #(
  parameter int words = 32
) (
  input  logic                   clock_50,
  input  logic                   rst_n,
  input  fabric_pkg::bus_req_t   req,
  input  logic                   rd,
  input  logic                   wr,
  output fabric_pkg::slave_rsp_t rsp
);

  localparam int aw = $clog2(words);

  logic [31:0]   mem [words];
  logic [31:0]   rdata_q;
  logic          wait_q;
  logic [aw-1:0] index;

  // byte offset to word index
  assign index = req.addr.f.offset[aw+1:2];

  // low for one cycle, then high again even if the strobe is held
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      wait_q <= 1'b1;
    end else begin
      wait_q <= ~((rd | wr) & wait_q);
    end
  end

  always_ff @(posedge clock_50) begin
    if (wr && wait_q) begin
      for (int b = 0; b < 4; b++) begin
        if (req.be[b]) begin
          mem[index][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
    if (rd && wait_q) begin
      rdata_q <= mem[index];
    end
  end

  assign rsp.rdata      = rdata_q;
  assign rsp.wait_level = wait_q;

endmodule

/* hw/io_regs.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module io_regs (
  input  logic                   clock_50,
  input  logic                   rst_n,
  input  fabric_pkg::bus_req_t   req,
  input  logic                   rd,
  input  logic                   wr,
  input  logic [15:0]            switches,
  output fabric_pkg::slave_rsp_t rsp,
  output logic [17:0]            leds,
  output logic [2:0]             interrupt
);

  logic [15:0] sw_meta;
  logic [15:0] sw_sync;
  logic [15:0] sw_prev;
  logic [31:0] reload_q;
  logic [31:0] reload_next;
  logic [31:0] count_q;
  logic [31:0] rdata_q;
  logic [1:0]  status_q;
  logic [1:0]  status_clr;
  logic [25:0] word;
  logic        wait_q;
  logic        access_rd;
  logic        access_wr;
  logic        timer_wr;
  logic        timer_tick;
  logic        sw_change;

  assign word      = req.addr.f.offset[27:2];
  assign access_rd = rd & wait_q;
  assign access_wr = wr & wait_q;
  assign timer_wr  = access_wr && (word == `IO_TIMER);
  assign sw_change = sw_sync != sw_prev;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      reload_next[8*b +: 8] = req.be[b] ? req.wdata[8*b +: 8] : reload_q[8*b +: 8];
    end
  end

  // reload of zero keeps the timer stopped
  assign timer_tick = (reload_q != 32'h0) && (count_q <= 32'd1) && !timer_wr;

  // write one to clear
  assign status_clr = (access_wr && (word == `IO_STATUS) && req.be[0]) ? req.wdata[1:0] : 2'b00;

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      wait_q   <= 1'b1;
      sw_meta  <= 16'h0;
      sw_sync  <= 16'h0;
      sw_prev  <= 16'h0;
      leds     <= 18'h0;
      reload_q <= 32'h0;
      count_q  <= 32'h0;
      status_q <= 2'b00;
    end else begin
      wait_q   <= ~((rd | wr) & wait_q);
      sw_meta  <= switches;
      sw_sync  <= sw_meta;
      sw_prev  <= sw_sync;
      status_q <= (status_q & ~status_clr) | {sw_change, timer_tick};
      if (access_wr && (word == `IO_LEDS)) begin
        if (req.be[0]) begin
          leds[7:0] <= req.wdata[7:0];
        end
        if (req.be[1]) begin
          leds[15:8] <= req.wdata[15:8];
        end
        if (req.be[2]) begin
          leds[17:16] <= req.wdata[17:16];
        end
      end
      if (timer_wr) begin
        reload_q <= reload_next;
        count_q  <= reload_next;
      end else if (reload_q != 32'h0) begin
        count_q <= (count_q <= 32'd1) ? reload_q : count_q - 32'd1;
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (access_rd) begin
      case (word)
        `IO_LEDS:     rdata_q <= {14'h0, leds};
        `IO_SWITCHES: rdata_q <= {16'h0, sw_sync};
        `IO_TIMER:    rdata_q <= reload_q;
        `IO_STATUS:   rdata_q <= {30'h0, status_q};
        default:      rdata_q <= 32'h0;
      endcase
    end
  end

  assign rsp.rdata      = rdata_q;
  assign rsp.wait_level = wait_q;

  // same encoding as the cpu interrupt hierarchy
  assign interrupt = (|status_q) ? {1'b1, status_q} : 3'b000;

endmodule

/* hw/bus_fabric_top.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module bus_fabric_top (
  input  logic        clock_50,
  input  logic        rst_n,
  input  logic [31:0] address,
  input  logic [31:0] writedata,
  input  logic [3:0]  be,
  input  logic        read,
  input  logic        write,
  output logic [31:0] readdata,
  output logic        wait_level,
  output logic        fault,
  input  logic [15:0] switches,
  output logic [17:0] leds,
  output logic [2:0]  interrupt
);

  fabric_pkg::bus_req_t   host_req;
  fabric_pkg::bus_req_t   stage_req;
  fabric_pkg::region_t    region;
  fabric_pkg::slave_rsp_t vect_rsp;
  fabric_pkg::slave_rsp_t scratch_rsp;
  fabric_pkg::slave_rsp_t io_rsp;
  logic                   done;
  logic                   vect_rd;
  logic                   vect_wr;
  logic                   scratch_rd;
  logic                   scratch_wr;
  logic                   io_rd;
  logic                   io_wr;

  assign host_req.addr.word = address;
  assign host_req.wdata     = writedata;
  assign host_req.be        = be;
  assign host_req.rd        = read;
  assign host_req.wr        = write;

  addr_decoder i_addr_decoder (
    .clock_50 (clock_50),
    .rst_n    (rst_n),
    .host_req (host_req),
    .done     (done),
    .stage_req(stage_req),
    .region   (region),
    .fault    (fault)
  );

  slave_router i_slave_router (
    .stage_req  (stage_req),
    .region     (region),
    .fault      (fault),
    .vect_rsp   (vect_rsp),
    .scratch_rsp(scratch_rsp),
    .io_rsp     (io_rsp),
    .vect_rd    (vect_rd),
    .vect_wr    (vect_wr),
    .scratch_rd (scratch_rd),
    .scratch_wr (scratch_wr),
    .io_rd      (io_rd),
    .io_wr      (io_wr),
    .readdata   (readdata),
    .wait_level (wait_level),
    .done       (done)
  );

  onchip_ram #(.words(`VECT_WORDS)) vect_ram (
    .clock_50(clock_50),
    .rst_n   (rst_n),
    .req     (stage_req),
    .rd      (vect_rd),
    .wr      (vect_wr),
    .rsp     (vect_rsp)
  );

  onchip_ram #(.words(`SCRATCH_WORDS)) scratch_ram (
    .clock_50(clock_50),
    .rst_n   (rst_n),
    .req     (stage_req),
    .rd      (scratch_rd),
    .wr      (scratch_wr),
    .rsp     (scratch_rsp)
  );

  io_regs i_io_regs (
    .clock_50 (clock_50),
    .rst_n    (rst_n),
    .req      (stage_req),
    .rd       (io_rd),
    .wr       (io_wr),
    .switches (switches),
    .rsp      (io_rsp),
    .leds     (leds),
    .interrupt(interrupt)
  );

endmodule

/* test/bus_fabric_chk.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module bus_fabric_chk (
  input logic        clock_50,
  input logic        rst_n,
  input logic [31:0] address,
  input logic        read,
  input logic        write,
  input logic        wait_level,
  input logic        fault,
  input logic [31:0] readdata,
  input logic [2:0]  interrupt
);

  logic mapped;
  logic status_read;

  assign mapped      = address[31:28] inside {`REGION_VECT, `REGION_SCRATCH, `REGION_IO};
  assign status_read = read && (address[31:28] == `REGION_IO) && (address[27:2] == `IO_STATUS);

  fault_one_cycle: assert property (@(posedge clock_50) disable iff (!rst_n)
    fault |=> !fault)
    else $error("fault held for more than one cycle");

  // slaves need a cycle before they answer
  wait_after_strobe: assert property (@(posedge clock_50) disable iff (!rst_n)
    $rose(read || write) && mapped |=> wait_level)
    else $error("wait low in the first cycle of a mapped request");

  // status seen empty on the bus, so no level was raised when it was captured
  irq_idle: assert property (@(posedge clock_50) disable iff (!rst_n)
    status_read && !wait_level && (readdata[1:0] == 2'b00) |-> $past(interrupt) == 3'b000)
    else $error("interrupt raised with empty status");

endmodule

bind bus_fabric_top bus_fabric_chk i_bus_fabric_chk (
  .clock_50  (clock_50),
  .rst_n     (rst_n),
  .address   (address),
  .read      (read),
  .write     (write),
  .wait_level(wait_level),
  .fault     (fault),
  .readdata  (readdata),
  .interrupt (interrupt)
);

/* test/bus_fabric_tb.sv */
`timescale 1ns/1ps
`include "fabric_consts.svh"

module bus_fabric_tb;

  localparam int num_ops   = 400;
  localparam int total_ops = 2 * (`VECT_WORDS + `SCRATCH_WORDS) + num_ops + 60;

  localparam logic [31:0] io_leds     = {`REGION_IO, 28'(`IO_LEDS * 4)};
  localparam logic [31:0] io_switches = {`REGION_IO, 28'(`IO_SWITCHES * 4)};
  localparam logic [31:0] io_timer    = {`REGION_IO, 28'(`IO_TIMER * 4)};
  localparam logic [31:0] io_status   = {`REGION_IO, 28'(`IO_STATUS * 4)};

  logic        clock_50;
  logic        rst_n;
  logic [31:0] address;
  logic [31:0] writedata;
  logic [3:0]  be;
  logic        read;
  logic        write;
  logic [15:0] switches;
  logic [31:0] readdata;
  logic        wait_level;
  logic        fault;
  logic [17:0] leds;
  logic [2:0]  interrupt;

  logic [31:0] vect_m [`VECT_WORDS];
  logic [31:0] scratch_m [`SCRATCH_WORDS];
  logic [31:0] rng;
  int          errors;
  int          checks;

  bus_fabric_top i_bus_fabric_top (.*);

  always #50 clock_50 = ~clock_50;

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                        input logic [3:0] ben);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (ben[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, want);
    end
  endtask

  // one host request held until wait drops, then one idle cycle
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] ben, input logic is_wr,
                            output logic [31:0] rdata);
    int   cycles;
    int   faults;
    logic mapped;
    mapped    = addr[31:28] inside {`REGION_VECT, `REGION_SCRATCH, `REGION_IO};
    cycles    = 0;
    faults    = 0;
    address   = addr;
    writedata = data;
    be        = ben;
    read      = !is_wr;
    write     = is_wr;
    do begin
      @(negedge clock_50);
      cycles++;
      if (fault) begin
        faults++;
      end
    end while (wait_level && cycles < 8);
    rdata = readdata;
    if (wait_level) begin
      errors++;
      $display("bus request to %h never completed", addr);
    end
    compare("wait cycles", cycles, mapped ? 2 : 1);
    if (!mapped && !is_wr) begin
      compare("unmapped readdata", rdata, 0);
    end
    @(negedge clock_50);
    if (fault) begin
      faults++;
    end
    read  = 1'b0;
    write = 1'b0;
    @(negedge clock_50);
    if (fault) begin
      faults++;
    end
    compare("fault pulses", faults, mapped ? 0 : 1);
  endtask

  // ram access with the model kept in step
  task automatic ram_access(input logic scratch, input logic [7:0] idx,
                            input logic [31:0] data, input logic [3:0] ben, input logic is_wr);
    logic [31:0] want;
    logic [31:0] got;
    logic [3:0]  nib;
    nib  = scratch ? `REGION_SCRATCH : `REGION_VECT;
    want = scratch ? scratch_m[idx] : vect_m[idx[4:0]];
    if (is_wr) begin
      want = merge(want, data, ben);
      if (scratch) begin
        scratch_m[idx] = want;
      end else begin
        vect_m[idx[4:0]] = want;
      end
    end
    bus_access({nib, 18'h0, idx, 2'b00}, data, ben, is_wr, got);
    if (!is_wr) begin
      compare(scratch ? "scratch readdata" : "vect readdata", got, want);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] data;
    logic [31:0] got;
    logic [3:0]  nib;
    int          polls;
    rng       = 32'd17;
    errors    = 0;
    checks    = 0;
    clock_50  = 1'b0;
    rst_n     = 1'b0;
    address   = '0;
    writedata = '0;
    be        = '0;
    read      = 1'b0;
    write     = 1'b0;
    switches  = '0;
    repeat (16) @(posedge clock_50);
    @(negedge clock_50);
    rst_n = 1'b1;
    compare("wait_level", 32'(wait_level), 1);
    compare("fault", 32'(fault), 0);
    compare("leds", 32'(leds), 0);
    compare("interrupt", 32'(interrupt), 0);

    for (int i = 0; i < `VECT_WORDS; i++) begin
      ram_access(1'b0, 8'(i), next_random(), 4'hf, 1'b1);
    end
    for (int i = 0; i < `SCRATCH_WORDS; i++) begin
      ram_access(1'b1, 8'(i), next_random(), 4'hf, 1'b1);
    end

    // mostly ram traffic, a quarter unmapped
    for (int n = 0; n < num_ops; n++) begin
      r    = next_random();
      data = next_random();
      if (r[2:0] < 3'd6) begin
        ram_access(r[3], r[3] ? r[15:8] : {3'b000, r[12:8]}, data, r[23:20], r[4]);
      end else begin
        nib = r[31:28];
        if (nib inside {`REGION_VECT, `REGION_SCRATCH, `REGION_IO}) begin
          nib = 4'hf;
        end
        bus_access({nib, data[27:0]}, data, r[23:20], r[4], got);
      end
    end

    // unmapped writes must not have touched the rams
    for (int i = 0; i < `VECT_WORDS; i++) begin
      ram_access(1'b0, 8'(i), 32'h0, 4'hf, 1'b0);
    end
    for (int i = 0; i < `SCRATCH_WORDS; i++) begin
      ram_access(1'b1, 8'(i), 32'h0, 4'hf, 1'b0);
    end

    for (int i = 0; i < 4; i++) begin
      data = next_random();
      bus_access(io_leds, data, 4'hf, 1'b1, got);
      compare("leds", 32'(leds), 32'(data[17:0]));
      bus_access(io_leds, 32'h0, 4'hf, 1'b0, got);
      compare("leds readback", got, 32'(data[17:0]));
    end

    for (int i = 0; i < 3; i++) begin
      switches = switches ^ (16'(next_random()) | 16'h1);
      // two sync flops and the change detect
      repeat (3) @(negedge clock_50);
      bus_access(io_switches, 32'h0, 4'hf, 1'b0, got);
      compare("switches readback", got, 32'(switches));
      compare("interrupt", 32'(interrupt), 32'({1'b1, 2'b10}));
      bus_access(io_status, 32'h0, 4'hf, 1'b0, got);
      compare("status", got, 32'h2);
      bus_access(io_status, 32'h2, 4'hf, 1'b1, got);
      compare("interrupt", 32'(interrupt), 0);
    end

    r    = next_random();
    data = {28'h0, r[3:0]} + 32'd8;
    bus_access(io_timer, data, 4'hf, 1'b1, got);
    bus_access(io_timer, 32'h0, 4'hf, 1'b0, got);
    compare("timer reload", got, data);
    polls = 0;
    got   = '0;
    while (!got[0] && polls < 16) begin
      bus_access(io_status, 32'h0, 4'hf, 1'b0, got);
      polls++;
    end
    compare("timer status", got, 32'h1);
    compare("interrupt", 32'(interrupt), 32'({1'b1, 2'b01}));
    bus_access(io_timer, 32'h0, 4'hf, 1'b1, got);
    bus_access(io_status, 32'h3, 4'hf, 1'b1, got);
    bus_access(io_status, 32'h0, 4'hf, 1'b0, got);
    compare("status after clear", got, 0);
    compare("interrupt", 32'(interrupt), 0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // an access takes four cycles, so twenty per op is ample
  initial begin
    #(total_ops * 20 * 100);
    $display("watchdog expired after %0d checks, the tests did not finish", checks);
    $display("Checks failed");
    $finish;
  end

endmodule

/* src.f */
+incdir+hw
hw/fabric_pkg.sv
hw/addr_decoder.sv
hw/slave_router.sv
hw/onchip_ram.sv
hw/io_regs.sv
hw/bus_fabric_top.sv
test/bus_fabric_chk.sv
test/bus_fabric_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= bus_fabric_tb
SEED      ?= 17
LOG       ?= sim.log
BUILD     ?= obj_dir

SRCS := $(filter-out +%,$(shell cat src.f))
HDRS := $(wildcard hw/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run check clean

all: run

$(BIN): src.f $(SRCS) $(HDRS)
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD) -f src.f

run: $(BIN)
	-$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
